//--- dso_capture.f
+incdir+source
source/dso_sample_pkg.sv
source/dso_mem_pkg.sv
source/decimator.sv
source/capture_fsm.sv
source/burst_packer.sv
source/level_measure.sv
source/dso_capture_top.sv
verif/tb_clock_gen.sv
verif/tb_dso_capture.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dso capture testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f dso_capture.f --top-module tb_dso_capture \
  -o sim_tb_dso_capture
status=$?
if [ $status -ne 0 ]; then
  echo "compile step failed with status $status"
  exit 1
fi

./obj_dir/sim_tb_dso_capture > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
exit 1

//--- source/burst_packer.sv
// sample to memory word packer
`timescale 1ns/1ns
`default_nettype none

`include "dso_macros.svh"

module burst_packer (
  input  wire                          ddr3_core_clk,
  input  wire                          resetn,
  input  wire dso_sample_pkg::sample_beat_t i_smp,
  output logic                         o_smp_ready,
  output dso_mem_pkg::wr_req_t         o_wr,
  output logic                         o_wr_valid,
  input  wire                          i_wr_ready,
  output logic                         o_drained
);

  // lane and burst counters wrap by overflow, both sizes are powers of two
  localparam int LANE_W  = $clog2(`DSO_BYTES_PER_WORD);
  localparam int BURST_W = $clog2(`DSO_BURST_LEN);
  localparam logic [LANE_W-1:0]  LAST_LANE = LANE_W'(`DSO_BYTES_PER_WORD - 1);
  localparam logic [BURST_W-1:0] LAST_BEAT = BURST_W'(`DSO_BURST_LEN - 1);

  dso_mem_pkg::mem_word_u asm_word;      // word being assembled
  dso_mem_pkg::mem_word_u asm_next;
  logic [LANE_W-1:0]      lane_idx;
  logic                   asm_full;      // complete word waiting for the output
  logic                   out_valid;
  logic                   out_last;
  dso_mem_pkg::mem_word_u out_data;
  logic [`DSO_MEM_SPACE_AW-1:0] out_addr;
  logic [`DSO_MEM_SPACE_AW-1:0] wr_addr;
  logic [BURST_W-1:0]     burst_pos;
  logic                   in_xfer;
  logic                   word_done;
  logic                   out_free;
  logic                   out_load;

  assign o_smp_ready = !asm_full;        // low only with both registers full
  assign in_xfer     = i_smp.valid && !asm_full;
  assign word_done   = in_xfer && (lane_idx == LAST_LANE);
  assign out_free    = !out_valid || i_wr_ready;
  assign out_load    = out_free && (asm_full || word_done);

  always_comb begin
    asm_next = asm_word;
    asm_next.lane[lane_idx] = i_smp.data;
  end

  // ********************
  // control
  // ********************
  always_ff @(posedge ddr3_core_clk or negedge resetn) begin
    if (!resetn) begin
      lane_idx  <= '0;
      asm_full  <= 1'b0;
      out_valid <= 1'b0;
      wr_addr   <= '0;
      burst_pos <= '0;
    end else begin
      if (in_xfer) lane_idx <= lane_idx + 1'b1;
      if (word_done && !out_free) asm_full <= 1'b1;   // park it
      else if (out_free) asm_full <= 1'b0;
      if (out_load) out_valid <= 1'b1;
      else if (i_wr_ready) out_valid <= 1'b0;
      if (out_load) begin
        wr_addr   <= wr_addr + 1'b1;                  // wraps at address space
        burst_pos <= burst_pos + 1'b1;
      end
    end
  end

  always_ff @(posedge ddr3_core_clk) begin
    if (in_xfer) asm_word <= asm_next;
    if (out_load) begin
      out_data.flat <= asm_full ? asm_word.flat : asm_next.flat;
      out_addr      <= wr_addr;
      out_last      <= (burst_pos == LAST_BEAT);
    end
  end

  assign o_wr       = '{addr: out_addr, data: out_data, last: out_last};
  assign o_wr_valid = out_valid;
  assign o_drained  = !out_valid && !asm_full && (lane_idx == '0);

endmodule

`default_nettype wire

//--- source/capture_fsm.sv
// trigger and capture window control
`timescale 1ns/1ns
`default_nettype none

`include "dso_macros.svh"

module capture_fsm (
  input  wire                            ddr3_core_clk,
  input  wire                            resetn,
  input  wire dso_sample_pkg::sample_beat_t i_deci,
  input  wire dso_sample_pkg::scope_ctrl_t  i_ctrl,
  output dso_sample_pkg::sample_beat_t   o_smp,
  input  wire                            i_smp_ready,
  input  wire                            i_drained,
  output logic                           o_done,
  output dso_sample_pkg::capture_state_t o_state
);

  localparam int CNT_W = $clog2(`DSO_CAPTURE_SAMPLES + 1);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`DSO_CAPTURE_SAMPLES);

  dso_sample_pkg::capture_state_t state;
  dso_sample_pkg::capture_state_t state_nxt;

  logic [`DSO_SAMPLE_W-1:0] prev_smp;    // previous kept sample while armed
  logic                     have_prev;
  logic                     pend_valid;
  logic [`DSO_SAMPLE_W-1:0] pend_data;
  logic [CNT_W-1:0]         load_cnt;    // samples taken into the window
  logic                     trig_hit;
  logic                     xfer;
  logic                     load;

  // ********************
  // trigger rule
  // ********************
  always_comb begin
    if (i_ctrl.trig_edge) begin
      trig_hit = have_prev && (prev_smp < i_ctrl.trig_level) &&
                 (i_deci.data >= i_ctrl.trig_level);
    end else begin
      trig_hit = have_prev && (prev_smp > i_ctrl.trig_level) &&
                 (i_deci.data <= i_ctrl.trig_level);
    end
  end

  assign xfer = pend_valid && i_smp_ready;

  // a sample arriving while one is still held gets dropped
  assign load = i_deci.valid &&
                (((state == dso_sample_pkg::ARMED) && trig_hit) ||
                 ((state == dso_sample_pkg::CAPTURE) && (load_cnt != LAST_CNT) &&
                  (!pend_valid || i_smp_ready)));

  always_comb begin
    state_nxt = state;
    case (state)
      dso_sample_pkg::IDLE: begin
        if (i_ctrl.run) state_nxt = dso_sample_pkg::ARMED;
      end
      dso_sample_pkg::ARMED: begin
        if (!i_ctrl.run) state_nxt = dso_sample_pkg::IDLE;
        else if (load) state_nxt = dso_sample_pkg::CAPTURE;   // trigger sample taken
      end
      dso_sample_pkg::CAPTURE: begin
        if (xfer && (load_cnt == LAST_CNT)) state_nxt = dso_sample_pkg::FLUSH;
      end
      dso_sample_pkg::FLUSH: begin
        if (i_drained) state_nxt = dso_sample_pkg::DONE;
      end
      dso_sample_pkg::DONE: begin
        state_nxt = i_ctrl.run ? dso_sample_pkg::ARMED : dso_sample_pkg::IDLE;
      end
      default: state_nxt = dso_sample_pkg::IDLE;
    endcase
  end

  always_ff @(posedge ddr3_core_clk or negedge resetn) begin
    if (!resetn) begin
      state      <= dso_sample_pkg::IDLE;
      have_prev  <= 1'b0;
      pend_valid <= 1'b0;
      load_cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (load) pend_valid <= 1'b1;
      else if (xfer) pend_valid <= 1'b0;
      // first kept sample after arming has no predecessor
      if (state != dso_sample_pkg::ARMED) have_prev <= 1'b0;
      else if (i_deci.valid) have_prev <= 1'b1;
      if (load) begin
        load_cnt <= (state == dso_sample_pkg::ARMED) ? CNT_W'(1) : load_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge ddr3_core_clk) begin
    if ((state == dso_sample_pkg::ARMED) && i_deci.valid) prev_smp <= i_deci.data;
    if (load) pend_data <= i_deci.data;
  end

  assign o_smp   = '{valid: pend_valid, data: pend_data};
  assign o_done  = (state == dso_sample_pkg::DONE);   // single cycle
  assign o_state = state;

endmodule

`default_nettype wire

//--- source/decimator.sv
// adc beat decimator
`timescale 1ns/1ns
`default_nettype none

`include "dso_macros.svh"

module decimator (
  input  wire                          ddr3_core_clk,
  input  wire                          resetn,
  input  wire dso_sample_pkg::sample_beat_t i_adc,
  input  wire                          i_run,
  input  wire [`DSO_DECI_W-1:0]        i_deci_rate,
  output dso_sample_pkg::sample_beat_t o_deci
);

  logic                     run_q;
  logic [`DSO_DECI_W-1:0]   beat_cnt;
  logic [`DSO_DECI_W-1:0]   cnt_now;
  logic                     keep;
  logic                     deci_valid;
  logic [`DSO_SAMPLE_W-1:0] deci_data;

  // counting restarts on run rising, so the first beat after it is kept
  assign cnt_now = (i_run && !run_q) ? '0 : beat_cnt;
  assign keep    = i_run && i_adc.valid && (cnt_now == '0);

  always_ff @(posedge ddr3_core_clk or negedge resetn) begin
    if (!resetn) begin
      run_q      <= 1'b0;
      beat_cnt   <= '0;
      deci_valid <= 1'b0;
    end else begin
      run_q      <= i_run;
      deci_valid <= keep;
      if (i_run && i_adc.valid) begin
        if (cnt_now == i_deci_rate) beat_cnt <= '0;   // rate+1 beats seen
        else beat_cnt <= cnt_now + 1'b1;
      end else begin
        beat_cnt <= cnt_now;
      end
    end
  end

  always_ff @(posedge ddr3_core_clk) begin
    if (keep) deci_data <= i_adc.data;
  end

  assign o_deci = '{valid: deci_valid, data: deci_data};

endmodule

`default_nettype wire

//--- source/dso_capture_top.sv
// dso capture path top
`timescale 1ns/1ns
`default_nettype none

module dso_capture_top (
  input  wire                          ddr3_core_clk,
  input  wire                          resetn,
  input  wire dso_sample_pkg::sample_beat_t i_adc,
  input  wire dso_sample_pkg::scope_ctrl_t  i_ctrl,
  output wire dso_mem_pkg::wr_req_t    o_wr,
  output wire                          o_wr_valid,
  input  wire                          i_wr_ready,
  output wire                          o_done,
  output wire dso_sample_pkg::meas_t   o_meas
);

  wire dso_sample_pkg::sample_beat_t deci_beat;   // kept adc beats
  wire dso_sample_pkg::sample_beat_t fsm_smp;     // fsm to packer stream
  wire dso_sample_pkg::sample_beat_t meas_smp;    // same stream, transfers only
  wire                               pk_ready;
  wire                               pk_drained;

  assign meas_smp = '{valid: fsm_smp.valid & pk_ready, data: fsm_smp.data};

  decimator decimator_inst (
    .ddr3_core_clk (ddr3_core_clk),
    .resetn        (resetn),
    .i_adc         (i_adc),
    .i_run         (i_ctrl.run),
    .i_deci_rate   (i_ctrl.deci_rate),
    .o_deci        (deci_beat)
  );

  capture_fsm capture_fsm_inst (
    .ddr3_core_clk (ddr3_core_clk),
    .resetn        (resetn),
    .i_deci        (deci_beat),
    .i_ctrl        (i_ctrl),
    .o_smp         (fsm_smp),
    .i_smp_ready   (pk_ready),
    .i_drained     (pk_drained),
    .o_done        (o_done),
    .o_state       ()
  );

  burst_packer burst_packer_inst (
    .ddr3_core_clk (ddr3_core_clk),
    .resetn        (resetn),
    .i_smp         (fsm_smp),
    .o_smp_ready   (pk_ready),
    .o_wr          (o_wr),
    .o_wr_valid    (o_wr_valid),
    .i_wr_ready    (i_wr_ready),
    .o_drained     (pk_drained)
  );

  level_measure level_measure_inst (
    .ddr3_core_clk (ddr3_core_clk),
    .resetn        (resetn),
    .i_smp         (meas_smp),
    .i_done        (o_done),
    .o_meas        (o_meas)
  );

endmodule

`default_nettype wire

//--- source/dso_macros.svh
// dso capture sizes
`ifndef DSO_MACROS_SVH
`define DSO_MACROS_SVH

// ********************
// sample path
// ********************

`define DSO_SAMPLE_W        8     // adc sample bits
`define DSO_DECI_W          10    // decimation rate bits

// one capture window
`define DSO_CAPTURE_SAMPLES 64

// ********************
// memory side
// ********************

`define DSO_BYTES_PER_WORD  4     // samples per memory word
`define DSO_WORD_W          (`DSO_SAMPLE_W * `DSO_BYTES_PER_WORD)

`define DSO_BURST_LEN       4     // words per write burst

// word address width, cut down so simulation wraps quickly
`define DSO_MEM_SPACE_AW    13

`endif

//--- source/dso_mem_pkg.sv
// memory write types
`default_nettype none

`include "dso_macros.svh"

package dso_mem_pkg;

  // ********************
  // memory word
  // ********************

  // filled lane by lane, handed to the controller as one word
  typedef union packed {
    logic [`DSO_BYTES_PER_WORD-1:0][`DSO_SAMPLE_W-1:0] lane;  // lane 0 oldest
    logic [`DSO_WORD_W-1:0]                            flat;
  } mem_word_u;

  // ********************
  // write request
  // ********************

  typedef struct packed {
    logic [`DSO_MEM_SPACE_AW-1:0] addr;   // word address
    mem_word_u                    data;
    logic                         last;   // final word of a burst
  } wr_req_t;

endpackage

`default_nettype wire

//--- source/dso_sample_pkg.sv
// sample path types
`default_nettype none

`include "dso_macros.svh"

package dso_sample_pkg;

  // one adc or decimated beat
  typedef struct packed {
    logic                     valid;
    logic [`DSO_SAMPLE_W-1:0] data;
  } sample_beat_t;

  // scope controls, only changed while run is low
  typedef struct packed {
    logic                     run;
    logic                     trig_edge;   // 1 = rising
    logic [`DSO_SAMPLE_W-1:0] trig_level;
    logic [`DSO_DECI_W-1:0]   deci_rate;   // keep 1 of rate+1 beats
  } scope_ctrl_t;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    ARMED   = 3'd1,
    CAPTURE = 3'd2,
    FLUSH   = 3'd3,
    DONE    = 3'd4
  } capture_state_t;

  // window measurement
  typedef struct packed {
    logic [`DSO_SAMPLE_W-1:0] max;
    logic [`DSO_SAMPLE_W-1:0] min;
    logic [`DSO_SAMPLE_W-1:0] vpp;   // max - min
  } meas_t;

endpackage

`default_nettype wire

//--- source/level_measure.sv
// window max min and peak to peak
`timescale 1ns/1ns
`default_nettype none

`include "dso_macros.svh"

module level_measure (
  input  wire                          ddr3_core_clk,
  input  wire                          resetn,
  input  wire dso_sample_pkg::sample_beat_t i_smp,   // transfers only
  input  wire                          i_done,
  output dso_sample_pkg::meas_t        o_meas
);

  logic                     first;       // next sample opens a window
  logic [`DSO_SAMPLE_W-1:0] run_max;
  logic [`DSO_SAMPLE_W-1:0] run_min;
  dso_sample_pkg::meas_t    meas_live;
  dso_sample_pkg::meas_t    meas_q;

  assign meas_live = '{max: run_max, min: run_min, vpp: run_max - run_min};

  always_ff @(posedge ddr3_core_clk or negedge resetn) begin
    if (!resetn) begin
      first  <= 1'b1;
      meas_q <= '0;
    end else begin
      if (i_done) begin
        first  <= 1'b1;                  // rearm for the next window
        meas_q <= meas_live;
      end else if (i_smp.valid) begin
        first <= 1'b0;
      end
    end
  end

  always_ff @(posedge ddr3_core_clk) begin
    if (i_smp.valid) begin
      if (first || (i_smp.data > run_max)) run_max <= i_smp.data;
      if (first || (i_smp.data < run_min)) run_min <= i_smp.data;
    end
  end

  // result shows in the done cycle itself, then holds
  assign o_meas = i_done ? meas_live : meas_q;

endmodule

`default_nettype wire

//--- verif/dso_capture_stim.txt
# test deci_rate trig_level trig_edge kind(0 ramp 1 triangle) stall first max min
# all fields hex, edge 1 = rising, max is taken from the data when stall is set
2 000 40 1 0 0 40 7f 40
3 003 fc 0 1 0 fb fb 00
4 001 20 1 0 0 20 9e 20
5 000 08 1 0 1 08 47 08

//--- verif/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_resetn
);

  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;   // 8 ns period
  end

  initial begin
    o_resetn = 1'b0;
    repeat (4) @(posedge o_clk);
    o_resetn <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_dso_capture.sv
// dso capture path testbench
`timescale 1ns/1ns
`default_nettype none

`include "dso_macros.svh"

module tb_dso_capture;

  logic ddr3_core_clk;
  logic resetn;
  dso_sample_pkg::sample_beat_t adc;
  dso_sample_pkg::scope_ctrl_t  ctrl;
  dso_mem_pkg::wr_req_t         wr;
  logic                         wr_valid;
  logic                         wr_ready;
  logic                         done;
  dso_sample_pkg::meas_t        meas;

  logic [31:0] t_num[8], t_rate[8], t_level[8], t_edge[8], t_kind[8];
  logic [31:0] t_stall[8], t_first[8], t_max[8], t_min[8];
  int          n_tests;
  int          errors;
  int          cycles;
  int          limit;
  logic        adc_on;
  logic        stall_en;
  logic [31:0] wave_kind;
  int          beat;
  logic [31:0] lfsr;
  logic [31:0] words[$];       // data of accepted words
  logic [31:0] addrs[$];
  logic        lasts[$];

  tb_clock_gen clock_gen_inst (.o_clk(ddr3_core_clk), .o_resetn(resetn));

  dso_capture_top dso_capture_top_inst (
    .ddr3_core_clk (ddr3_core_clk),
    .resetn        (resetn),
    .i_adc         (adc),
    .i_ctrl        (ctrl),
    .o_wr          (wr),
    .o_wr_valid    (wr_valid),
    .i_wr_ready    (wr_ready),
    .o_done        (done),
    .o_meas        (meas)
  );

  // ********************
  // helpers
  // ********************
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
  endfunction

  function automatic logic [7:0] wave(input logic [31:0] kind, input int p);
    logic [8:0] q;
    q = p[8:0];
    if (kind == 0) return p[7:0];           // ramp
    return (q < 256) ? q[7:0] : 8'(511 - q);   // triangle of period 512
  endfunction

  // index of the trigger among kept samples
  function automatic int trigger_index(input int t);
    logic [7:0] prev;
    logic [7:0] cur;
    for (int k = 0; k < 4096; k++) begin
      cur = wave(t_kind[t], k * (t_rate[t] + 1));
      if (k > 0) begin
        if (t_edge[t][0] && prev < t_level[t][7:0] && cur >= t_level[t][7:0]) return k;
        if (!t_edge[t][0] && prev > t_level[t][7:0] && cur <= t_level[t][7:0]) return k;
      end
      prev = cur;
    end
    return -1;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      errors++;
      $display("FAIL t=%0t %s expected=%0h got=%0h", $time, name, exp, got);
    end
  endtask

  // ********************
  // stimulus and memory side
  // ********************
  always @(posedge ddr3_core_clk) begin
    if (adc_on) begin
      adc  <= '{valid: 1'b1, data: wave(wave_kind, beat)};
      beat <= beat + 1;
    end else begin
      adc  <= '0;
      beat <= 0;
    end
    if (stall_en) begin
      lfsr = lfsr_step(lfsr);
      wr_ready <= lfsr[0];
    end else begin
      wr_ready <= 1'b1;
    end
    if (resetn && wr_valid && wr_ready) begin
      words.push_back(wr.data.flat);
      addrs.push_back(32'(wr.addr));
      lasts.push_back(wr.last);
    end
  end

  // watchdog
  always @(posedge ddr3_core_clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, o_done never came", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    int         fd;
    int         n;
    int         k0;
    int         addr_exp;
    string      line;
    logic [7:0] b;
    logic [7:0] prev_b;
    logic [7:0] first_b;
    logic [7:0] exp_max;
    logic [7:0] exp_min;
    logic [7:0] exp_vpp;
    dso_sample_pkg::meas_t got_meas;
    adc = '0;
    ctrl = '0;
    wr_ready = 1'b1;
    adc_on = 1'b0;
    stall_en = 1'b0;
    wave_kind = 0;
    beat = 0;
    lfsr = 32'he3a5;
    errors = 0;
    cycles = 0;
    limit = 100000;
    n_tests = 0;
    addr_exp = 0;
    fd = $fopen("verif/dso_capture_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      $display("Simulation FAILED");
      $finish;
    end else begin
      while (!$feof(fd) && n_tests < 8) begin
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", t_num[n_tests], t_rate[n_tests],
                      t_level[n_tests], t_edge[n_tests], t_kind[n_tests], t_stall[n_tests],
                      t_first[n_tests], t_max[n_tests], t_min[n_tests]);
          if (n == 9) n_tests++;
        end
      end
      $fclose(fd);
      limit = 2000;
      for (int t = 0; t < n_tests; t++) limit += 10 * (t_rate[t] + 1) * 64 * 2;

      // reset and idle
      wait (resetn);
      @(posedge ddr3_core_clk);
      check_val("o_wr_valid", 0, 32'(wr_valid));
      check_val("o_done", 0, 32'(done));
      check_val("o_meas", 0, 32'(meas));
      adc_on <= 1'b1;                          // adc beats arrive with run low
      repeat (20) @(posedge ddr3_core_clk);
      check_val("idle words", 0, words.size());
      adc_on <= 1'b0;

      for (int t = 0; t < n_tests; t++) begin
        words.delete();
        addrs.delete();
        lasts.delete();
        ctrl      <= '{run: 1'b0, trig_edge: t_edge[t][0], trig_level: t_level[t][7:0],
                       deci_rate: t_rate[t][9:0]};
        wave_kind <= t_kind[t];
        stall_en  <= t_stall[t][0];
        @(posedge ddr3_core_clk);
        ctrl.run <= 1'b1;
        adc_on   <= 1'b1;
        do @(posedge ddr3_core_clk); while (!done);
        got_meas = meas;
        ctrl.run <= 1'b0;
        adc_on   <= 1'b0;
        stall_en <= 1'b0;
        for (int c = 0; c < 10; c++) begin
          @(posedge ddr3_core_clk);
          check_val("o_done", 0, 32'(done));   // single cycle pulse
        end

        $display("test %0d: %0d words", t_num[t], words.size());
        check_val("word count", 16, words.size());
        k0 = trigger_index(t);
        for (int w = 0; w < words.size(); w++) begin
          check_val("o_wr.addr", addr_exp, addrs[w]);
          check_val("o_wr.last", 32'((w % 4) == 3), 32'(lasts[w]));
          addr_exp = (addr_exp + 1) % (1 << `DSO_MEM_SPACE_AW);   // wraps
          for (int l = 0; l < 4; l++) begin
            b = words[w][l*8 +: 8];
            if (w == 0 && l == 0) begin
              first_b = b;
              check_val("o_wr.data first byte", t_first[t], 32'(b));
            end else if (t_stall[t][0]) begin
              if (b <= prev_b) begin
                errors++;
                $display("bytes out of order in test %0d at word %0d lane %0d", t_num[t], w, l);
              end
            end else begin
              check_val("o_wr.data byte",
                        32'(wave(t_kind[t], (k0 + w*4 + l) * (t_rate[t] + 1))), 32'(b));
            end
            prev_b = b;
          end
        end
        // under stall some samples drop and the max is the last byte kept
        exp_max = t_stall[t][0] ? prev_b : t_max[t][7:0];
        exp_min = t_stall[t][0] ? t_first[t][7:0] : t_min[t][7:0];
        exp_vpp = exp_max - exp_min;
        check_val("o_meas.max", 32'(exp_max), 32'(got_meas.max));
        check_val("o_meas.min", 32'(exp_min), 32'(got_meas.min));
        check_val("o_meas.vpp", 32'(exp_vpp), 32'(got_meas.vpp));
      end

      $display("tests=%0d errors=%0d cycles=%0d", n_tests, errors, cycles);
      if (errors == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
